// ==== be_director_top.f ====
design/be_cfg_pkg.sv
design/fe_cmd_pkg.sv
design/npc_tracker.sv
design/branch_outcome_tracker.sv
design/fe_cmd_arbiter.sv
design/be_director_top.sv
tb/be_director_tb.sv

// ==== Makefile ====
# Verilator build for the back-end director testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= be_director_tb
FILELIST  ?= be_director_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?=

SOURCES := $(wildcard design/*.sv) $(wildcard tb/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: $(BIN)
	./$(BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/be_director_tb.sv ====
// Back-end director testbench
// Reference model plus concurrent checks over boot, branch, trap, config and freeze traffic
`timescale 1ns/100ps
`default_nettype none

module be_director_tb;

   import be_cfg_pkg::*;
   import fe_cmd_pkg::*;

   localparam int vw_lp = vaddr_width_gp;
   localparam int mw_lp = metadata_width_gp;
   localparam logic [vw_lp-1:0] reset_pc_lp = reset_pc_gp;
   // Scenarios need a few hundred cycles, so this limit is a wide margin
   localparam int timeout_cycles_lp = 2000;

   typedef logic [vw_lp-1:0] vaddr_t;
   typedef enum logic [1:0] {m_reset, m_boot, m_run, m_fence} model_state_e;

   logic clk_i;
   logic reset_i;
   logic freeze_i;
   logic cfg_npc_w_v_i;
   vaddr_t cfg_npc_i;
   vaddr_t cfg_npc_data_o;
   logic isd_v_i;
   vaddr_t isd_pc_i;
   logic [mw_lp-1:0] isd_metadata_i;
   vaddr_t expected_npc_o;
   logic poison_iss_o, suppress_iss_o, flush_o;
   logic ex1_v_i, ex1_instr_v_i, ex1_br_or_jmp_i, ex1_btaken_i;
   vaddr_t ex1_npc_i;
   logic fencei_i, exception_i, interrupt_i, eret_i, rollback_i;
   vaddr_t trap_npc_i;
   logic fe_cmd_v_o;
   fe_opcode_e fe_cmd_opcode_o;
   vaddr_t fe_cmd_vaddr_o;
   fe_subop_e fe_cmd_subop_o;
   mispredict_reason_e fe_cmd_reason_o;
   logic fe_cmd_taken_o;
   logic [mw_lp-1:0] fe_cmd_metadata_o;
   logic fe_cmd_ready_i, fe_cmd_fence_i;

   // Reference model state and outputs
   model_state_e model_state;
   vaddr_t model_npc, model_expected, model_vaddr;
   logic model_br_pend, model_tk_pend, model_last_br, model_last_tk, model_mismatch;
   logic model_v, model_taken, model_flush, model_poison, model_suppress, model_mispredict;
   fe_opcode_e model_op;
   fe_subop_e model_subop;
   mispredict_reason_e model_reason;
   logic [mw_lp-1:0] model_meta;
   int cycle_count = 0;

   be_director_top
     #(.vaddr_width_p(vw_lp)
      ,.metadata_width_p(mw_lp)
      ,.reset_pc_p(reset_pc_lp)
      )
   uut (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   task automatic stop_run_failed(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped on the first error");
   endtask

   task automatic report_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      stop_run_failed($sformatf("error: %s is %h, expected %h", name, got, exp));
   endtask

   always @(posedge clk_i)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles_lp)
         stop_run_failed($sformatf("Timeout after %0d cycles", timeout_cycles_lp));
   end

   // Later writes win, so cfg beats traps and traps beat ex1
   always_comb
   begin
      model_expected = model_npc;
      if (ex1_instr_v_i)
         model_expected = ex1_npc_i;
      if (fencei_i | exception_i | interrupt_i | eret_i | rollback_i)
         model_expected = trap_npc_i;
      if (cfg_npc_w_v_i)
         model_expected = cfg_npc_i;
   end

   assign model_last_br  = model_br_pend | (ex1_v_i & ex1_br_or_jmp_i);
   assign model_last_tk  = model_tk_pend | (ex1_v_i & ex1_btaken_i);
   assign model_mismatch = isd_v_i && (isd_pc_i != model_expected);

   always_comb
   begin
      model_v = 1'b0;
      model_op = state_reset;
      model_vaddr = '0;
      model_subop = trap;
      model_reason = not_a_branch;
      model_taken = 1'b0;
      model_meta = '0;
      model_flush = 1'b0;
      model_mispredict = 1'b0;
      if (model_state == m_boot && !freeze_i)
      begin
         model_v = fe_cmd_ready_i;
         model_vaddr = model_npc;
      end
      else if ((model_state == m_run || model_state == m_fence) && !freeze_i)
      begin
         if (fencei_i || exception_i || interrupt_i || eret_i)
         begin
            model_v = fe_cmd_ready_i;
            model_op = fencei_i ? icache_fence : pc_redirect;
            model_vaddr = trap_npc_i;
            model_flush = 1'b1;
         end
         else if (rollback_i)
            model_flush = 1'b1;
         else if (model_mismatch || (isd_v_i && model_last_br))
         begin
            model_v = fe_cmd_ready_i;
            model_vaddr = model_expected;
            model_meta = isd_metadata_i;
            model_mispredict = model_mismatch;
            model_op = model_mismatch ? pc_redirect : attaboy;
            model_subop = model_mismatch ? branch_mispredict : trap;
            model_taken = model_last_tk;
            if (model_last_br)
               model_reason = model_last_tk ? incorrect_pred_taken : incorrect_pred_ntaken;
         end
      end
      model_poison = model_flush | model_mismatch;
      model_suppress = model_flush | (model_state == m_fence && fe_cmd_fence_i);
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         model_state <= m_reset;
         model_npc <= reset_pc_lp;
         model_br_pend <= 1'b0;
         model_tk_pend <= 1'b0;
      end
      else
      begin
         model_npc <= model_expected;
         if (isd_v_i)
         begin
            model_br_pend <= 1'b0;
            model_tk_pend <= 1'b0;
         end
         else if (ex1_v_i)
         begin
            model_br_pend <= ex1_br_or_jmp_i;
            model_tk_pend <= ex1_btaken_i;
         end
         case (model_state)
            m_reset: if (!freeze_i) model_state <= m_boot;
            m_boot:  if (model_v) model_state <= m_run;
            m_run:
               if (freeze_i)
                  model_state <= m_reset;
               else if (model_v && model_op != attaboy)
                  model_state <= m_fence;
            default: if (!fe_cmd_fence_i) model_state <= m_run;
         endcase
      end
   end

   a_cmd_v : assert property (@(posedge clk_i) disable iff (reset_i) fe_cmd_v_o == model_v)
      else report_value("fe_cmd_v_o", 64'(fe_cmd_v_o), 64'(model_v));
   a_cmd_op : assert property (@(posedge clk_i) disable iff (reset_i)
      model_v |-> fe_cmd_opcode_o == model_op)
      else report_value("fe_cmd_opcode_o", 64'(fe_cmd_opcode_o), 64'(model_op));
   a_cmd_vaddr : assert property (@(posedge clk_i) disable iff (reset_i)
      model_v |-> fe_cmd_vaddr_o == model_vaddr)
      else report_value("fe_cmd_vaddr_o", 64'(fe_cmd_vaddr_o), 64'(model_vaddr));
   a_cmd_subop : assert property (@(posedge clk_i) disable iff (reset_i)
      (model_v && model_op == pc_redirect) |-> fe_cmd_subop_o == model_subop)
      else report_value("fe_cmd_subop_o", 64'(fe_cmd_subop_o), 64'(model_subop));
   a_cmd_reason : assert property (@(posedge clk_i) disable iff (reset_i)
      (model_v && model_mispredict) |-> fe_cmd_reason_o == model_reason)
      else report_value("fe_cmd_reason_o", 64'(fe_cmd_reason_o), 64'(model_reason));
   a_cmd_taken : assert property (@(posedge clk_i) disable iff (reset_i)
      (model_v && model_op == attaboy) |-> fe_cmd_taken_o == model_taken)
      else report_value("fe_cmd_taken_o", 64'(fe_cmd_taken_o), 64'(model_taken));
   a_cmd_meta : assert property (@(posedge clk_i) disable iff (reset_i)
      (model_v && (model_mispredict || model_op == attaboy)) |-> fe_cmd_metadata_o == model_meta)
      else report_value("fe_cmd_metadata_o", 64'(fe_cmd_metadata_o), 64'(model_meta));
   a_flush : assert property (@(posedge clk_i) disable iff (reset_i) flush_o == model_flush)
      else report_value("flush_o", 64'(flush_o), 64'(model_flush));
   a_poison : assert property (@(posedge clk_i) disable iff (reset_i) poison_iss_o == model_poison)
      else report_value("poison_iss_o", 64'(poison_iss_o), 64'(model_poison));
   a_suppress : assert property (@(posedge clk_i) disable iff (reset_i)
      suppress_iss_o == model_suppress)
      else report_value("suppress_iss_o", 64'(suppress_iss_o), 64'(model_suppress));
   a_cfg_data : assert property (@(posedge clk_i) disable iff (reset_i)
      cfg_npc_data_o == model_npc)
      else report_value("cfg_npc_data_o", 64'(cfg_npc_data_o), 64'(model_npc));
   a_expected_npc : assert property (@(posedge clk_i) disable iff (reset_i)
      expected_npc_o == model_expected)
      else report_value("expected_npc_o", 64'(expected_npc_o), 64'(model_expected));

   function automatic logic coin();
      int r;
      r = $urandom % 2;
      return (r == 1);
   endfunction

   function automatic vaddr_t random_vaddr();
      logic [63:0] r;
      r = {$urandom, $urandom};
      return {r[vw_lp-1:2], 2'b00};
   endfunction

   function automatic logic [mw_lp-1:0] random_meta();
      logic [31:0] r;
      r = $urandom;
      return r[mw_lp-1:0];
   endfunction

   task automatic clear_inputs();
      cfg_npc_w_v_i = 1'b0;
      isd_v_i = 1'b0;
      ex1_v_i = 1'b0;
      ex1_instr_v_i = 1'b0;
      ex1_br_or_jmp_i = 1'b0;
      ex1_btaken_i = 1'b0;
      fencei_i = 1'b0;
      exception_i = 1'b0;
      interrupt_i = 1'b0;
      eret_i = 1'b0;
      rollback_i = 1'b0;
   endtask

   // Random ready until the state_reset command is taken
   task automatic wait_boot_accept();
      logic accepted;
      accepted = 1'b0;
      while (!accepted)
      begin
         @(negedge clk_i);
         clear_inputs();
         fe_cmd_ready_i = coin();
         #1;
         accepted = fe_cmd_v_o;
      end
   endtask

   task automatic stall_fe();
      int n;
      n = $urandom % 4;
      repeat (n)
      begin
         @(negedge clk_i);
         clear_inputs();
         fe_cmd_ready_i = 1'b0;
      end
   endtask

   task automatic branch_then_issue(input logic is_branch, input logic taken,
                                    input vaddr_t target, input vaddr_t issue_pc);
      @(negedge clk_i);
      clear_inputs();
      fe_cmd_ready_i = 1'b1;
      ex1_v_i = 1'b1;
      ex1_instr_v_i = 1'b1;
      ex1_br_or_jmp_i = is_branch;
      ex1_btaken_i = is_branch & taken;
      ex1_npc_i = target;
      // Outcome must survive idle cycles before the issue
      stall_fe();
      @(negedge clk_i);
      clear_inputs();
      fe_cmd_ready_i = 1'b1;
      isd_v_i = 1'b1;
      isd_pc_i = issue_pc;
      isd_metadata_i = random_meta();
      @(negedge clk_i);
      clear_inputs();
   endtask

   task automatic send_trap(input string kind, input vaddr_t target, input logic ready,
                            input int fence_cycles);
      @(negedge clk_i);
      clear_inputs();
      fe_cmd_ready_i = ready;
      fe_cmd_fence_i = (fence_cycles > 0);
      trap_npc_i = target;
      if (kind == "fencei")
         fencei_i = 1'b1;
      else if (kind == "exception")
         exception_i = 1'b1;
      else if (kind == "interrupt")
         interrupt_i = 1'b1;
      else if (kind == "eret")
         eret_i = 1'b1;
      else
         rollback_i = 1'b1;
      // FE ready during the fence, so any stray command would show
      repeat (fence_cycles)
      begin
         @(negedge clk_i);
         clear_inputs();
         fe_cmd_ready_i = 1'b1;
      end
      @(negedge clk_i);
      clear_inputs();
      fe_cmd_fence_i = 1'b0;
   endtask

   task automatic random_traffic(input int cycles);
      repeat (cycles)
      begin
         @(negedge clk_i);
         clear_inputs();
         fe_cmd_ready_i = coin() | coin();
         ex1_v_i = coin();
         ex1_instr_v_i = ex1_v_i;
         ex1_br_or_jmp_i = coin();
         ex1_btaken_i = ex1_br_or_jmp_i & coin();
         ex1_npc_i = random_vaddr();
         isd_v_i = coin();
         isd_metadata_i = random_meta();
         #1;
         isd_pc_i = coin() ? model_expected : random_vaddr();
      end
      @(negedge clk_i);
      clear_inputs();
   endtask

   initial
   begin
      void'($urandom(19));
      reset_i = 1'b1;
      freeze_i = 1'b0;
      clear_inputs();
      cfg_npc_i = '0;
      isd_pc_i = '0;
      isd_metadata_i = '0;
      ex1_npc_i = '0;
      trap_npc_i = '0;
      fe_cmd_ready_i = 1'b0;
      fe_cmd_fence_i = 1'b0;
      repeat (10) @(negedge clk_i);
      reset_i = 1'b0;

      wait_boot_accept();

      // Mispredictions, taken, not taken and not a branch
      branch_then_issue(1'b1, 1'b1, 39'h00_8000_0100, 39'h00_8000_0004);
      branch_then_issue(1'b1, 1'b0, 39'h00_8000_0208, 39'h00_8000_0300);
      branch_then_issue(1'b0, 1'b0, 39'h00_8000_0310, 39'h00_8000_0400);

      // Correct predictions
      branch_then_issue(1'b1, 1'b1, 39'h00_8000_0500, 39'h00_8000_0500);
      branch_then_issue(1'b1, 1'b0, 39'h00_8000_0504, 39'h00_8000_0504);

      send_trap("exception", 39'h00_0000_1000, 1'b1, 4);
      send_trap("fencei", 39'h00_8000_0600, 1'b1, 2);
      send_trap("rollback", 39'h00_8000_0640, 1'b1, 0);
      send_trap("interrupt", 39'h00_0000_1004, 1'b1, 1);
      // Dropped by the FE, flush still raised
      send_trap("eret", 39'h00_8000_0700, 1'b0, 0);

      @(negedge clk_i);
      clear_inputs();
      fe_cmd_ready_i = 1'b1;
      cfg_npc_w_v_i = 1'b1;
      cfg_npc_i = 39'h00_9000_0040;
      @(negedge clk_i);
      clear_inputs();

      // Freeze in run, with an issue that must not reach the FE
      @(negedge clk_i);
      freeze_i = 1'b1;
      isd_v_i = 1'b1;
      isd_pc_i = 39'h00_1234_5678;
      repeat (3)
      begin
         @(negedge clk_i);
         clear_inputs();
      end
      freeze_i = 1'b0;
      wait_boot_accept();

      random_traffic(60);

      @(negedge clk_i);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/be_director_top.sv ====
// Back-end director
// Tracks the NPC, watches branch outcomes and sends commands to the front end
`timescale 1ns/100ps
`default_nettype none

module be_director_top
  #(parameter int vaddr_width_p    = be_cfg_pkg::vaddr_width_gp
   ,parameter int metadata_width_p = be_cfg_pkg::metadata_width_gp
   ,parameter logic [vaddr_width_p-1:0] reset_pc_p = be_cfg_pkg::reset_pc_gp
   )
   (input  logic                           clk_i
   ,input  logic                           reset_i
   ,input  logic                           freeze_i

   // Configuration port
   ,input  logic                           cfg_npc_w_v_i
   ,input  logic [vaddr_width_p-1:0]       cfg_npc_i
   ,output logic [vaddr_width_p-1:0]       cfg_npc_data_o

   // Issue stage
   ,input  logic                           isd_v_i
   ,input  logic [vaddr_width_p-1:0]       isd_pc_i
   ,input  logic [metadata_width_p-1:0]    isd_metadata_i
   ,output logic [vaddr_width_p-1:0]       expected_npc_o
   ,output logic                           poison_iss_o
   ,output logic                           suppress_iss_o

   // Execute stage
   ,input  logic                           ex1_v_i
   ,input  logic                           ex1_instr_v_i
   ,input  logic [vaddr_width_p-1:0]       ex1_npc_i
   ,input  logic                           ex1_br_or_jmp_i
   ,input  logic                           ex1_btaken_i

   // Traps
   ,input  logic                           fencei_i
   ,input  logic                           exception_i
   ,input  logic                           interrupt_i
   ,input  logic                           eret_i
   ,input  logic                           rollback_i
   ,input  logic [vaddr_width_p-1:0]       trap_npc_i
   ,output logic                           flush_o

   // FE command link
   ,output logic                           fe_cmd_v_o
   ,output fe_cmd_pkg::fe_opcode_e         fe_cmd_opcode_o
   ,output logic [vaddr_width_p-1:0]       fe_cmd_vaddr_o
   ,output fe_cmd_pkg::fe_subop_e          fe_cmd_subop_o
   ,output fe_cmd_pkg::mispredict_reason_e fe_cmd_reason_o
   ,output logic                           fe_cmd_taken_o
   ,output logic [metadata_width_p-1:0]    fe_cmd_metadata_o
   ,input  logic                           fe_cmd_ready_i
   ,input  logic                           fe_cmd_fence_i
   );

   logic [vaddr_width_p-1:0] npc_r;
   logic                     npc_mismatch;
   logic                     last_was_branch;
   logic                     last_was_taken;
   logic                     trap_v;

   assign trap_v = fencei_i | exception_i | interrupt_i | eret_i | rollback_i;

   assign cfg_npc_data_o = npc_r;

   npc_tracker
     #(.vaddr_width_p(vaddr_width_p)
      ,.reset_pc_p(reset_pc_p)
      )
   npc_tracker_inst
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.cfg_npc_w_v_i(cfg_npc_w_v_i)
      ,.cfg_npc_i(cfg_npc_i)
      ,.ex1_instr_v_i(ex1_instr_v_i)
      ,.ex1_npc_i(ex1_npc_i)
      ,.trap_v_i(trap_v)
      ,.trap_npc_i(trap_npc_i)
      ,.isd_v_i(isd_v_i)
      ,.isd_pc_i(isd_pc_i)
      ,.npc_r_o(npc_r)
      ,.expected_npc_o(expected_npc_o)
      ,.npc_mismatch_o(npc_mismatch)
      );

   branch_outcome_tracker branch_outcome_tracker_inst
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.ex1_v_i(ex1_v_i)
      ,.ex1_br_or_jmp_i(ex1_br_or_jmp_i)
      ,.ex1_btaken_i(ex1_btaken_i)
      ,.isd_v_i(isd_v_i)
      ,.last_was_branch_o(last_was_branch)
      ,.last_was_taken_o(last_was_taken)
      );

   fe_cmd_arbiter
     #(.vaddr_width_p(vaddr_width_p)
      ,.metadata_width_p(metadata_width_p)
      )
   fe_cmd_arbiter_inst
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.freeze_i(freeze_i)
      ,.fe_cmd_ready_i(fe_cmd_ready_i)
      ,.fe_cmd_fence_i(fe_cmd_fence_i)
      ,.fencei_i(fencei_i)
      ,.exception_i(exception_i)
      ,.interrupt_i(interrupt_i)
      ,.eret_i(eret_i)
      ,.rollback_i(rollback_i)
      ,.trap_npc_i(trap_npc_i)
      ,.isd_v_i(isd_v_i)
      ,.isd_metadata_i(isd_metadata_i)
      ,.npc_r_i(npc_r)
      ,.expected_npc_i(expected_npc_o)
      ,.npc_mismatch_i(npc_mismatch)
      ,.last_was_branch_i(last_was_branch)
      ,.last_was_taken_i(last_was_taken)
      ,.fe_cmd_v_o(fe_cmd_v_o)
      ,.fe_cmd_opcode_o(fe_cmd_opcode_o)
      ,.fe_cmd_vaddr_o(fe_cmd_vaddr_o)
      ,.fe_cmd_subop_o(fe_cmd_subop_o)
      ,.fe_cmd_reason_o(fe_cmd_reason_o)
      ,.fe_cmd_taken_o(fe_cmd_taken_o)
      ,.fe_cmd_metadata_o(fe_cmd_metadata_o)
      ,.flush_o(flush_o)
      ,.poison_iss_o(poison_iss_o)
      ,.suppress_iss_o(suppress_iss_o)
      );

endmodule

`default_nettype wire

// ==== design/fe_cmd_arbiter.sv ====
// FE command arbiter
// Boot state machine and priority choice of the command, flush, poison and suppress
`timescale 1ns/100ps
`default_nettype none

module fe_cmd_arbiter
  #(parameter int vaddr_width_p    = be_cfg_pkg::vaddr_width_gp
   ,parameter int metadata_width_p = be_cfg_pkg::metadata_width_gp
   )
   (input  logic                                clk_i
   ,input  logic                                reset_i

   ,input  logic                                freeze_i
   ,input  logic                                fe_cmd_ready_i
   ,input  logic                                fe_cmd_fence_i

   // Trap sources
   ,input  logic                                fencei_i
   ,input  logic                                exception_i
   ,input  logic                                interrupt_i
   ,input  logic                                eret_i
   ,input  logic                                rollback_i
   ,input  logic [vaddr_width_p-1:0]            trap_npc_i

   // Issue stage
   ,input  logic                                isd_v_i
   ,input  logic [metadata_width_p-1:0]         isd_metadata_i

   // From the NPC and branch trackers
   ,input  logic [vaddr_width_p-1:0]            npc_r_i
   ,input  logic [vaddr_width_p-1:0]            expected_npc_i
   ,input  logic                                npc_mismatch_i
   ,input  logic                                last_was_branch_i
   ,input  logic                                last_was_taken_i

   // FE command
   ,output logic                                fe_cmd_v_o
   ,output fe_cmd_pkg::fe_opcode_e              fe_cmd_opcode_o
   ,output logic [vaddr_width_p-1:0]            fe_cmd_vaddr_o
   ,output fe_cmd_pkg::fe_subop_e               fe_cmd_subop_o
   ,output fe_cmd_pkg::mispredict_reason_e      fe_cmd_reason_o
   ,output logic                                fe_cmd_taken_o
   ,output logic [metadata_width_p-1:0]         fe_cmd_metadata_o

   ,output logic                                flush_o
   ,output logic                                poison_iss_o
   ,output logic                                suppress_iss_o
   );

   import fe_cmd_pkg::*;

   typedef enum logic [1:0] {e_reset, e_boot, e_run, e_fence} state_e;

   state_e state_r;
   state_e state_n;
   logic   cmd_nonattaboy_v;

   // Any command except attaboy puts the FE into a fence
   assign cmd_nonattaboy_v = fe_cmd_v_o & (fe_cmd_opcode_o != attaboy);

   always_comb
   begin
      case (state_r)
         e_reset: state_n = freeze_i ? e_reset : e_boot;
         e_boot:  state_n = fe_cmd_v_o ? e_run : e_boot;
         e_run:   state_n = freeze_i ? e_reset : (cmd_nonattaboy_v ? e_fence : e_run);
         e_fence: state_n = fe_cmd_fence_i ? e_fence : e_run;
         default: state_n = e_reset;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         state_r <= e_reset;
      else
         state_r <= state_n;
   end

   // Priority selection, highest first
   always_comb
   begin
      fe_cmd_v_o        = 1'b0;
      fe_cmd_opcode_o   = state_reset;
      fe_cmd_vaddr_o    = '0;
      fe_cmd_subop_o    = trap;
      fe_cmd_reason_o   = not_a_branch;
      fe_cmd_taken_o    = 1'b0;
      fe_cmd_metadata_o = '0;
      flush_o           = 1'b0;

      if ((state_r == e_reset) || freeze_i)
      begin
         // Held quiet
         fe_cmd_v_o = 1'b0;
      end
      else if (state_r == e_boot)
      begin
         fe_cmd_opcode_o = state_reset;
         fe_cmd_vaddr_o  = npc_r_i;
         fe_cmd_v_o      = fe_cmd_ready_i;
      end
      else if (fencei_i)
      begin
         fe_cmd_opcode_o = icache_fence;
         fe_cmd_vaddr_o  = trap_npc_i;
         fe_cmd_v_o      = fe_cmd_ready_i;
         flush_o         = 1'b1;
      end
      else if (exception_i | interrupt_i | eret_i)
      begin
         fe_cmd_opcode_o = pc_redirect;
         fe_cmd_vaddr_o  = trap_npc_i;
         fe_cmd_subop_o  = trap;
         fe_cmd_v_o      = fe_cmd_ready_i;
         flush_o         = 1'b1;
      end
      else if (rollback_i)
      begin
         // Replay from the trap NPC without telling the FE
         flush_o = 1'b1;
      end
      else if (npc_mismatch_i)
      begin
         fe_cmd_opcode_o   = pc_redirect;
         fe_cmd_vaddr_o    = expected_npc_i;
         fe_cmd_subop_o    = branch_mispredict;
         fe_cmd_metadata_o = isd_metadata_i;
         if (!last_was_branch_i)
            fe_cmd_reason_o = not_a_branch;
         else if (last_was_taken_i)
            fe_cmd_reason_o = incorrect_pred_taken;
         else
            fe_cmd_reason_o = incorrect_pred_ntaken;
         fe_cmd_v_o = fe_cmd_ready_i;
      end
      else if (isd_v_i & last_was_branch_i)
      begin
         // Prediction was right
         fe_cmd_opcode_o   = attaboy;
         fe_cmd_vaddr_o    = expected_npc_i;
         fe_cmd_taken_o    = last_was_taken_i;
         fe_cmd_metadata_o = isd_metadata_i;
         fe_cmd_v_o        = fe_cmd_ready_i;
      end
   end

   // Poison the instruction in issue on a flush or a wrong path
   assign poison_iss_o   = flush_o | npc_mismatch_i;
   assign suppress_iss_o = flush_o | ((state_r == e_fence) & fe_cmd_fence_i);

   // A command handed to the FE is accepted and carries a known target
   a_valid_needs_ready : assert property (
      @(posedge clk_i) disable iff (reset_i)
      fe_cmd_v_o |-> (fe_cmd_ready_i && !$isunknown(fe_cmd_vaddr_o))
   ) else $error("fe_cmd_arbiter: command sent while FE not ready or with unknown vaddr");

   // State never picks up X from the inputs
   a_state_legal : assert property (
      @(posedge clk_i) disable iff (reset_i)
      !$isunknown(state_r)
   ) else $error("fe_cmd_arbiter: state is unknown");

endmodule

`default_nettype wire

// ==== design/branch_outcome_tracker.sv ====
// Branch outcome tracker
// Remembers the last resolved branch and its direction until the next issue
`timescale 1ns/100ps
`default_nettype none

module branch_outcome_tracker
   (input  logic clk_i
   ,input  logic reset_i

   // Execute stage result
   ,input  logic ex1_v_i
   ,input  logic ex1_br_or_jmp_i
   ,input  logic ex1_btaken_i

   // Issue stage handshake
   ,input  logic isd_v_i

   ,output logic last_was_branch_o
   ,output logic last_was_taken_o
   );

   logic branch_pending_r;
   logic taken_pending_r;
   logic ex1_branch;
   logic ex1_taken;
   logic pending_en;

   assign ex1_branch = ex1_v_i & ex1_br_or_jmp_i;
   assign ex1_taken  = ex1_v_i & ex1_btaken_i;

   // Update on a new ex1 result, clear on issue
   assign pending_en = ex1_v_i | isd_v_i;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         branch_pending_r <= 1'b0;
         taken_pending_r  <= 1'b0;
      end
      else if (pending_en)
      begin
         // An instruction issuing this cycle consumes the outcome already
         branch_pending_r <= ex1_branch & ~isd_v_i;
         taken_pending_r  <= ex1_taken & ~isd_v_i;
      end
   end

   // Same-cycle ex1 result is forwarded so issue sees it without delay
   assign last_was_branch_o = branch_pending_r | ex1_branch;
   assign last_was_taken_o  = taken_pending_r | ex1_taken;

endmodule

`default_nettype wire

// ==== design/npc_tracker.sv ====
// NPC tracker
// Holds the architectural next PC and flags issuing PCs that disagree with it
`timescale 1ns/100ps
`default_nettype none

module npc_tracker
  #(parameter int vaddr_width_p = be_cfg_pkg::vaddr_width_gp
   ,parameter logic [vaddr_width_p-1:0] reset_pc_p = be_cfg_pkg::reset_pc_gp
   )
   (input  logic                     clk_i
   ,input  logic                     reset_i

   // Configuration overwrite
   ,input  logic                     cfg_npc_w_v_i
   ,input  logic [vaddr_width_p-1:0] cfg_npc_i

   // Resolved next PC from execute
   ,input  logic                     ex1_instr_v_i
   ,input  logic [vaddr_width_p-1:0] ex1_npc_i

   // Any trap, fence or rollback
   ,input  logic                     trap_v_i
   ,input  logic [vaddr_width_p-1:0] trap_npc_i

   // Instruction at issue
   ,input  logic                     isd_v_i
   ,input  logic [vaddr_width_p-1:0] isd_pc_i

   ,output logic [vaddr_width_p-1:0] npc_r_o
   ,output logic [vaddr_width_p-1:0] expected_npc_o
   ,output logic                     npc_mismatch_o
   );

   logic [vaddr_width_p-1:0] npc_r;
   logic [vaddr_width_p-1:0] npc_n;
   logic                     npc_w_v;

   assign npc_w_v = cfg_npc_w_v_i | ex1_instr_v_i | trap_v_i;

   // Configuration wins over traps, traps win over the normal ex1 flow
   always_comb
   begin
      if (cfg_npc_w_v_i)
         npc_n = cfg_npc_i;
      else if (trap_v_i)
         npc_n = trap_npc_i;
      else
         npc_n = ex1_npc_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         npc_r <= reset_pc_p;
      else if (npc_w_v)
         npc_r <= npc_n;
   end

   // Bypass so that issue compares against the value being written
   assign expected_npc_o = npc_w_v ? npc_n : npc_r;

   assign npc_mismatch_o = isd_v_i & (isd_pc_i != expected_npc_o);

   assign npc_r_o = npc_r;

   // An issuing PC must be known for the mismatch compare to mean anything
   a_issue_pc_known : assert property (
      @(posedge clk_i) disable iff (reset_i)
      isd_v_i |-> !$isunknown(isd_pc_i)
   ) else $error("npc_tracker: issuing PC is unknown");

   // The NPC register never loads an unknown value
   a_npc_known : assert property (
      @(posedge clk_i) disable iff (reset_i)
      !$isunknown(npc_r)
   ) else $error("npc_tracker: NPC register is unknown");

endmodule

`default_nettype wire

// ==== design/fe_cmd_pkg.sv ====
// FE command package
// Opcodes, redirect subopcodes and misprediction reasons sent to the front end
`default_nettype none

package fe_cmd_pkg;

   // Command opcode seen by the FE
   typedef enum logic [1:0]
   {
      state_reset  = 2'd0,
      pc_redirect  = 2'd1,
      icache_fence = 2'd2,
      attaboy      = 2'd3
   } fe_opcode_e;

   // Why a pc_redirect was sent
   typedef enum logic
   {
      trap              = 1'b0,
      branch_mispredict = 1'b1
   } fe_subop_e;

   // Reason attached to a branch_mispredict redirect
   // The FE uses it to train its predictor in the right direction
   typedef enum logic [1:0]
   {
      not_a_branch          = 2'd0,
      incorrect_pred_taken  = 2'd1,
      incorrect_pred_ntaken = 2'd2
   } mispredict_reason_e;

endpackage

`default_nettype wire

// ==== design/be_cfg_pkg.sv ====
// Core configuration package
// Address and metadata widths plus the boot PC of the back-end director
`default_nettype none

package be_cfg_pkg;

   // Virtual address width of the core
   localparam int vaddr_width_gp = 39;

   // Branch metadata forwarded from the FE and handed back on redirects
   localparam int metadata_width_gp = 8;

   // PC used by the first state_reset command after boot
   localparam logic [vaddr_width_gp-1:0] reset_pc_gp = 39'h00_8000_0000;

endpackage

`default_nettype wire
